// File: sim.f
common/twdl_pkg.sv
hdl/twdl_ctrl.sv
hdl/twdl_index_cnt.sv
hdl/twdl_phase_acc.sv
cordic/cordic_rotator.sv
hdl/twdl_gen_top.sv
verif/twdl_gen_sva.sv
verif/twdl_gen_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the run from the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module twdl_gen_tb -f sim.f \
	> build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtwdl_gen_tb 2>&1 | tee sim.log || { echo "simulation aborted"; exit 1; }

grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: verif/twdl_gen_tb.sv
/* Testbench for the twiddle generator. Sweeps a table of stage configurations and checks
   tag order, latency, busy and all four coefficients against a floating-point model. */
`timescale 1ns/1ps
`default_nettype none

module twdl_gen_tb import twdl_pkg::*; ();

	typedef struct packed {
		logic [TWDL_W_IDX-1:0] len;
		logic [TWDL_W_IDX-1:0] den;
		logic [7:0]            abort_at;  // cycles to a second start (0 for none)
	} row_t;

	logic      clk;
	logic      rst_n;
	logic      start;
	twdl_cfg_t cfg;
	twdl_out_t out;
	logic      busy;

	integer seed = 32'h8b3200d1;
	int     tag_errs;
	int     coef_errs;
	int     bit_errs;
	int     other_errs;

	// rows with N = 16 and 48 wrap past a full turn
	// N = 1200 and 300 give long remainder carry chains
	// last row restarts mid-sweep
	row_t rows [8] = '{
		'{12'd8, 12'd16, 8'd0},
		'{12'd12, 12'd48, 8'd0},
		'{12'd20, 12'd1200, 8'd0},
		'{12'd5, 12'd3, 8'd0},
		'{12'd1, 12'd1, 8'd0},
		'{12'd16, 12'd300, 8'd0},
		'{12'd300, 12'd300, 8'd0},
		'{12'd40, 12'd1200, 8'd8}
	};

	twdl_gen_top u_twdl_gen_top (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.cfg   (cfg),
		.out   (out),
		.busy  (busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// reference model
	function automatic int round_real(real r);
		if (r >= 0.0)
			return $rtoi(r + 0.5);
		return -$rtoi(-r + 0.5);
	endfunction

	// exact floor(k * 2^20 / N)
	function automatic longint ref_theta(int k, int n);
		return (longint'(k) << TWDL_W_PH) / n;
	endfunction

	// cos and -sin of m * theta_k at the nominal gain
	function automatic twdl_cplx_t ref_coef(int k, int n, int m);
		longint     ang;
		real        w;
		twdl_cplx_t c;
		ang  = (ref_theta(k, n) * m) % (longint'(1) << TWDL_W_PH);
		w    = 2.0 * 3.14159265358979 * real'(ang) / 1048576.0;
		c.re = TWDL_W_OUT'(round_real(9948.0 * 1.647 * $cos(w)));
		c.im = TWDL_W_OUT'(round_real(-9948.0 * 1.647 * $sin(w)));
		return c;
	endfunction

	// --------------------
	// compare tasks
	task automatic check_tag(string name, twdl_tag_t got, twdl_tag_t exp);
		if (got !== exp) begin
			tag_errs++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_cplx(string name, twdl_cplx_t got, twdl_cplx_t exp);
		int d_re;
		int d_im;
		d_re = int'(got.re) - int'(exp.re);
		d_im = int'(got.im) - int'(exp.im);
		// gain mismatch and truncation in the iterations stay within 6 LSB
		if ($isunknown(got) || d_re > 6 || d_re < -6 || d_im > 6 || d_im < -6) begin
			coef_errs++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			bit_errs++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	// --------------------
	// one table row from start until busy is low
	task automatic run_row(row_t row);
		int        cyc;
		int        n_old;
		int        total;
		int        k;
		bit        seen;
		twdl_tag_t exp_tag;
		twdl_cfg_t c;
		c.len    = row.len;
		c.den    = row.den;
		c.step_q = TWDL_W_PH'((longint'(1) << TWDL_W_PH) / row.den);
		c.step_r = TWDL_W_IDX'((longint'(1) << TWDL_W_PH) % row.den);
		@(posedge clk);
		start <= 1'b1;
		cfg   <= c;
		cyc  = 0;
		seen = 1'b0;
		// wait for the first result and restart on the way if the row asks
		while (!seen && cyc < 100) begin
			@(negedge clk);
			if (out.tag.valid === 1'b1) begin
				seen = 1'b1;
			end else begin
				// busy rises in the cycle after the start strobe
				check_bit("busy", busy, cyc > 0);
				@(posedge clk);
				cyc++;
				start <= (row.abort_at != 0 && cyc == int'(row.abort_at));
			end
		end
		if (!seen) begin
			other_errs++;
			$display("no result within 100 cycles of start, len %0d den %0d", row.len, row.den);
			return;
		end
		if (cyc != TWDL_LATENCY + 1) begin
			other_errs++;
			$display("first result came %0d cycles after start instead of %0d", cyc,
				TWDL_LATENCY + 1);
		end
		// the aborted sweep drains first and the restarted one follows back to back
		n_old = row.abort_at;
		total = n_old + row.len;
		for (int j = 0; j < total; j++) begin
			if (j > 0) begin
				@(posedge clk);
				@(negedge clk);
			end
			k = (j < n_old) ? j : j - n_old;
			exp_tag.valid = 1'b1;
			exp_tag.last  = (j == total - 1);
			exp_tag.index = TWDL_W_IDX'(k);
			check_tag("out.tag", out.tag, exp_tag);
			for (int m = 0; m < 4; m++)
				check_cplx($sformatf("out.coef[%0d]", m), out.coef[m], ref_coef(k, row.den, m));
		end
		check_bit("busy", busy, 1'b1);
		// busy falls after the last result and nothing may follow it
		cyc = 0;
		while (busy !== 1'b0 && cyc < 100) begin
			@(posedge clk);
			@(negedge clk);
			cyc++;
			check_bit("out.tag.valid", out.tag.valid, 1'b0);
		end
		if (busy !== 1'b0) begin
			other_errs++;
			$display("busy still high 100 cycles after the final result");
		end
	endtask

	// --------------------
	// main sequence
	initial begin
		int gap;
		rst_n      = 1'b0;
		start      = 1'b0;
		cfg        = '0;
		tag_errs   = 0;
		coef_errs  = 0;
		bit_errs   = 0;
		other_errs = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			gap = 1 + ({$random(seed)} % 8);
			repeat (gap) @(posedge clk);
			run_row(rows[i]);
		end
		repeat (5) @(posedge clk);
		$display("errors: tag %0d, coef %0d, bit %0d, other %0d", tag_errs, coef_errs,
			bit_errs, other_errs);
		if (tag_errs + coef_errs + bit_errs + other_errs == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/twdl_gen_sva.sv
/* Assertions on start-to-result timing, tag order and reset state, bound to the top. */
`timescale 1ns/1ps
`default_nettype none

module twdl_gen_sva import twdl_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input logic      start,
	input twdl_out_t out,
	input logic      busy
);

	// --------------------
	// first result of every sweep, also after a restart
	a_start_to_valid: assert property (
		@(posedge clk) disable iff (!rst_n)
		start |-> ##(TWDL_LATENCY + 1) out.tag.valid
	) else $error("no valid result 23 cycles after start");

	// index steps by one, except where a restarted sweep begins at 0
	a_index_step: assert property (
		@(posedge clk) disable iff (!rst_n)
		(out.tag.valid && $past(out.tag.valid) && out.tag.index != '0)
			|-> (out.tag.index == $past(out.tag.index) + 12'd1)
	) else $error("index of consecutive results did not increment");

	// idle right out of reset
	a_reset_idle: assert property (
		@(posedge clk) $rose(rst_n) |-> (!busy && !out.tag.valid)
	) else $error("busy or valid set after reset");

endmodule

bind twdl_gen_top twdl_gen_sva u_sva (
	.clk   (clk),
	.rst_n (rst_n),
	.start (start),
	.out   (out),
	.busy  (busy)
);

`default_nettype wire

// File: hdl/twdl_gen_top.sv
/* Twiddle generator for one radix-4 stage: a start strobe with a configuration gives
   len results, each carrying exp(-j*2*pi*m*k/N) for m = 0..3 and an index tag. */
`timescale 1ns/1ps
`default_nettype none

module twdl_gen_top import twdl_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start,
	input  twdl_cfg_t cfg,
	output twdl_out_t out,
	output logic      busy
);

	twdl_cfg_t             cfg_q;
	logic                  cnt_clear;
	logic                  run;
	logic                  issue;
	logic                  last;
	logic [TWDL_W_IDX-1:0] idx;
	twdl_angle_u [3:0]     angle;
	twdl_tag_t             tag;
	twdl_cplx_t [3:0]      coef;

	// --------------------
	// control and index
	twdl_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.cfg         (cfg),
		.last_issued (last),
		.issue       (issue),
		.idx         (idx),
		.cfg_q       (cfg_q),
		.cnt_clear   (cnt_clear),
		.run         (run),
		.tag         (tag),
		.busy        (busy)
	);

	twdl_index_cnt u_cnt (
		.clk   (clk),
		.rst_n (rst_n),
		.clear (cnt_clear),
		.run   (run),
		.len   (cfg_q.len),
		.issue (issue),
		.idx   (idx),
		.last  (last)
	);

	// --------------------
	// phase and rotators
	twdl_phase_acc u_acc (
		.clk   (clk),
		.rst_n (rst_n),
		.issue (issue),
		.idx   (idx),
		.cfg   (cfg_q),
		.angle (angle)
	);

	// one rotator per multiple m
	for (genvar m = 0; m < 4; m++) begin : g_rot
		cordic_rotator u_rot (
			.clk   (clk),
			.rst_n (rst_n),
			.angle (angle[m]),
			.coef  (coef[m])
		);
	end

	assign out.tag  = tag;
	assign out.coef = coef;

endmodule

`default_nettype wire

// File: cordic/cordic_rotator.sv
/* Pipelined rotation-mode CORDIC turning a phase word into cos and -sin.
   One fold register, one register per iteration and one output register. */
`timescale 1ns/1ps
`default_nettype none

module cordic_rotator import twdl_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  twdl_angle_u angle,
	output twdl_cplx_t  coef
);

	logic signed [CORDIC_W_XY-1:0] x_pipe [0:CORDIC_STAGES];
	logic signed [CORDIC_W_XY-1:0] y_pipe [0:CORDIC_STAGES];
	logic        [TWDL_W_PH-1:0]   z_pipe [0:CORDIC_STAGES-1];
	logic signed [CORDIC_W_XY-1:0] x_init;
	logic signed [CORDIC_W_XY-1:0] x_rnd;
	logic signed [CORDIC_W_XY-1:0] y_rnd;

	// start vector with guard bits below the output LSB
	assign x_init = CORDIC_W_XY'(CORDIC_GAIN_X0) <<< CORDIC_GUARD;

	// --------------------
	// quadrant fold
	// residual angle always ends up within +-90 deg
	// quad 0 and 3 rotate from (x0, 0) directly
	// quad 1 starts at +90 deg, quad 2 at -90 deg
	always_ff @(posedge clk) begin
		// upper bits sign extend the fine angle for quad 2 and 3
		z_pipe[0] <= {{2{angle.q.quad[1]}}, angle.q.fine};
		case (angle.q.quad)
			2'd1: begin
				x_pipe[0] <= '0;
				y_pipe[0] <= x_init;
			end
			2'd2: begin
				x_pipe[0] <= '0;
				y_pipe[0] <= -x_init;
			end
			default: begin
				x_pipe[0] <= x_init;
				y_pipe[0] <= '0;
			end
		endcase
	end

	// --------------------
	// iterations
	for (genvar i = 0; i < CORDIC_STAGES; i++) begin : g_iter
		// rotate toward zero residual, direction from the sign of z
		always_ff @(posedge clk) begin
			if (!z_pipe[i][TWDL_W_PH-1]) begin
				x_pipe[i+1] <= x_pipe[i] - (y_pipe[i] >>> i);
				y_pipe[i+1] <= y_pipe[i] + (x_pipe[i] >>> i);
			end else begin
				x_pipe[i+1] <= x_pipe[i] + (y_pipe[i] >>> i);
				y_pipe[i+1] <= y_pipe[i] - (x_pipe[i] >>> i);
			end
		end

		// last stage has no further use for the residual
		if (i < CORDIC_STAGES - 1) begin : g_z
			always_ff @(posedge clk) begin
				if (!z_pipe[i][TWDL_W_PH-1])
					z_pipe[i+1] <= z_pipe[i] - cordic_atan[i];
				else
					z_pipe[i+1] <= z_pipe[i] + cordic_atan[i];
			end
		end
	end

	// --------------------
	// output, round off guard bits
	assign x_rnd = x_pipe[CORDIC_STAGES] + CORDIC_W_XY'(2 ** (CORDIC_GUARD - 1));
	assign y_rnd = y_pipe[CORDIC_STAGES] + CORDIC_W_XY'(2 ** (CORDIC_GUARD - 1));

	// conjugate, exp(-j theta) = cos - j sin
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			coef <= '0;
		end else begin
			coef.re <= TWDL_W_OUT'(x_rnd >>> CORDIC_GUARD);
			coef.im <= TWDL_W_OUT'(-(y_rnd >>> CORDIC_GUARD));
		end
	end

endmodule

`default_nettype wire

// File: hdl/twdl_phase_acc.sv
/* Phase accumulator giving theta_k = floor(k * 2^20 / N) exactly, by carrying the
   remainder modulo N, and registering the multiples 0, 1, 2 and 3 times theta. */
`timescale 1ns/1ps
`default_nettype none

module twdl_phase_acc import twdl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue,
	input  logic [TWDL_W_IDX-1:0] idx,
	input  twdl_cfg_t             cfg,
	output twdl_angle_u [3:0]     angle
);

	logic [TWDL_W_PH-1:0]  q_acc;
	logic [TWDL_W_IDX-1:0] r_acc;
	logic [TWDL_W_IDX:0]   r_sum;
	logic                  carry;
	logic [TWDL_W_PH-1:0]  theta_nxt;
	logic [TWDL_W_IDX-1:0] r_nxt;

	// --------------------
	// next accumulator value
	always_comb begin
		// both remainders are below den, so one extra bit holds the sum
		r_sum = {1'b0, r_acc} + {1'b0, cfg.step_r};
		carry = (r_sum >= {1'b0, cfg.den});
		if (idx == '0) begin
			theta_nxt = '0;
			r_nxt     = '0;
		end else begin
			theta_nxt = q_acc + cfg.step_q + TWDL_W_PH'(carry);
			if (carry)
				r_nxt = TWDL_W_IDX'(r_sum - {1'b0, cfg.den});
			else
				r_nxt = r_sum[TWDL_W_IDX-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q_acc <= '0;
			r_acc <= '0;
		end else if (issue) begin
			q_acc <= theta_nxt;
			r_acc <= r_nxt;
		end
	end

	// --------------------
	// multiples, wrapping mod 2^20 for free
	// built from the next value so they come out in the same cycle as theta
	always_ff @(posedge clk) begin
		if (issue) begin
			angle[0].raw <= '0;
			angle[1].raw <= theta_nxt;
			angle[2].raw <= theta_nxt << 1;
			angle[3].raw <= (theta_nxt << 1) + theta_nxt;
		end
	end

endmodule

`default_nettype wire

// File: hdl/twdl_index_cnt.sv
/* Index counter for one sweep: runs k from 0 to len-1 after a clear and flags the
   final index combinationally. */
`timescale 1ns/1ps
`default_nettype none

module twdl_index_cnt import twdl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  clear,
	input  logic                  run,
	input  logic [TWDL_W_IDX-1:0] len,
	output logic                  issue,
	output logic [TWDL_W_IDX-1:0] idx,
	output logic                  last
);

	// clear restarts at 0 even in the middle of a sweep
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue <= 1'b0;
			idx   <= '0;
		end else if (clear) begin
			issue <= 1'b1;
			idx   <= '0;
		end else if (issue) begin
			// stop after the final index or when control leaves run
			if (last || !run)
				issue <= 1'b0;
			else
				idx <= idx + TWDL_W_IDX'(1);
		end
	end

	assign last = issue && (idx == len - TWDL_W_IDX'(1));

endmodule

`default_nettype wire

// File: hdl/twdl_ctrl.sv
/* Sweep control: holds the configuration, sequences idle, run and drain, and carries
   the index tag alongside the rotators so it leaves together with the coefficients. */
`timescale 1ns/1ps
`default_nettype none

module twdl_ctrl import twdl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  twdl_cfg_t             cfg,
	input  logic                  last_issued,
	input  logic                  issue,
	input  logic [TWDL_W_IDX-1:0] idx,
	output twdl_cfg_t             cfg_q,
	output logic                  cnt_clear,
	output logic                  run,
	output twdl_tag_t             tag,
	output logic                  busy
);

	typedef enum logic [1:0] {IDLE, RUN, DRAIN} state_t;

	state_t                  state;
	logic [TWDL_W_DRAIN-1:0] drain_cnt;
	twdl_tag_t               tag_pipe [CORDIC_LAT+1];

	// --------------------
	// config latch, taken with the start strobe
	always_ff @(posedge clk) begin
		if (start)
			cfg_q <= cfg;
	end

	// --------------------
	// state machine
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= IDLE;
			cnt_clear <= 1'b0;
			drain_cnt <= '0;
		end else begin
			cnt_clear <= start;
			// start wins in any state, a running sweep is simply restarted
			if (start) begin
				state <= RUN;
			end else begin
				case (state)
					RUN: begin
						// ignore a stale last from an aborted sweep while clearing
						if (last_issued && !cnt_clear) begin
							state     <= DRAIN;
							drain_cnt <= TWDL_W_DRAIN'(CORDIC_LAT);
						end
					end
					DRAIN: begin
						// hits zero in the cycle the last tag leaves the delay line
						if (drain_cnt == '0)
							state <= IDLE;
						else
							drain_cnt <= drain_cnt - 1'b1;
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	assign run  = (state == RUN);
	assign busy = (state != IDLE);

	// --------------------
	// tag delay line, one stage for the accumulator plus the rotator depth
	always_ff @(posedge clk) begin
		tag_pipe[0] <= '{valid: issue, last: last_issued, index: idx};
		for (int i = 1; i <= CORDIC_LAT; i++)
			tag_pipe[i] <= tag_pipe[i-1];
		// only the valid bits need clearing
		if (!rst_n) begin
			for (int i = 0; i <= CORDIC_LAT; i++)
				tag_pipe[i].valid <= 1'b0;
		end
	end

	assign tag = tag_pipe[CORDIC_LAT];

endmodule

`default_nettype wire

// File: common/twdl_pkg.sv
/* Shared widths, latencies, CORDIC constants and bus types of the twiddle generator.
   Modules pull these in with a wildcard import in their header. */
`default_nettype none

package twdl_pkg;

	// --------------------
	// widths and latency
	localparam int TWDL_W_IDX    = 12;
	localparam int TWDL_W_PH     = 20;  // 2^20 per full turn
	localparam int TWDL_W_OUT    = 16;
	localparam int CORDIC_STAGES = 18;
	localparam int CORDIC_LAT    = 20;  // fold + iterations + output
	localparam int TWDL_LATENCY  = 22;  // counter + accumulator + rotator
	localparam int CORDIC_GUARD  = 2;   // extra fraction bits inside the rotator
	localparam int CORDIC_W_XY   = TWDL_W_OUT + CORDIC_GUARD;
	localparam int TWDL_W_DRAIN  = $clog2(CORDIC_LAT + 1);

	// 16384 / 1.647, so the rotated vector lands near full scale
	localparam int CORDIC_GAIN_X0 = 9948;

	// atan(2^-i) as a fraction of a turn, scaled by 2^20
	localparam logic [TWDL_W_PH-1:0] cordic_atan [CORDIC_STAGES] = '{
		20'd131072, 20'd77376, 20'd40883, 20'd20753, 20'd10417, 20'd5213,
		20'd2607, 20'd1304, 20'd652, 20'd326, 20'd163, 20'd81,
		20'd41, 20'd20, 20'd10, 20'd5, 20'd3, 20'd1
	};

	// --------------------
	// bus types
	typedef struct packed {
		logic [TWDL_W_IDX-1:0] len;     // indices per sweep
		logic [TWDL_W_IDX-1:0] den;     // DFT length N
		logic [TWDL_W_PH-1:0]  step_q;  // floor(2^20 / N)
		logic [TWDL_W_IDX-1:0] step_r;  // 2^20 mod N
	} twdl_cfg_t;

	typedef struct packed {
		logic                  valid;
		logic                  last;
		logic [TWDL_W_IDX-1:0] index;
	} twdl_tag_t;

	typedef struct packed {
		logic [1:0]           quad;
		logic [TWDL_W_PH-3:0] fine;
	} twdl_quad_t;

	// same phase word, seen as a raw turn fraction or split by quadrant
	typedef union packed {
		logic [TWDL_W_PH-1:0] raw;
		twdl_quad_t           q;
	} twdl_angle_u;

	typedef struct packed {
		logic signed [TWDL_W_OUT-1:0] re;
		logic signed [TWDL_W_OUT-1:0] im;
	} twdl_cplx_t;

	typedef struct packed {
		twdl_tag_t        tag;
		twdl_cplx_t [3:0] coef;  // one entry per m
	} twdl_out_t;

endpackage

`default_nettype wire
